// File: Makefile
TOP       ?= tb_csr_file
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= tb.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/csr_exc_regs.sv
`timescale 1ns/1ns

module csr_exc_regs (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic [csr_pkg::NUM_W-1:0]            csr_num,
    input  logic                                 csr_we,
    input  logic [csr_pkg::DATA_W-1:0]           csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]           csr_wvalue,
    input  logic                                 wb_ex,
    input  logic [csr_pkg::DATA_W-1:0]           wb_pc,
    input  logic [csr_pkg::DATA_W-1:0]           wb_vaddr,
    input  logic [5:0]                           wb_ecode,
    input  logic [8:0]                           wb_esubcode,
    input  logic                                 ertn_flush,
    input  logic [7:0]                           hw_int_in,
    input  logic                                 ipi_int_in,
    output logic [csr_pkg::PLV_W-1:0]            crmd_plv,
    output logic                                 crmd_ie,
    output logic [csr_pkg::PLV_W-1:0]            prmd_pplv,
    output logic                                 prmd_pie,
    output logic [csr_pkg::IS_W-1:0]             ecfg_lie,
    output logic [csr_pkg::IS_W-1:0]             estat_is,
    output logic [5:0]                           estat_ecode,
    output logic [8:0]                           estat_esubcode,
    output logic [csr_pkg::DATA_W-1:0]           era_pc,
    output logic [csr_pkg::DATA_W-1:0]           badv_vaddr,
    output logic [csr_pkg::EENTRY_VA_W-1:0]      eentry_va
);

    localparam int VA_LSB = csr_pkg::DATA_W - csr_pkg::EENTRY_VA_W;

    logic [csr_pkg::DATA_W-1:0] wr_set;
    logic [csr_pkg::DATA_W-1:0] wr_keep;
    logic                       wr_crmd;
    logic                       wr_prmd;
    logic                       wr_ecfg;
    logic                       wr_estat;
    logic                       wr_era;
    logic                       wr_eentry;
    logic                       addr_err;
    logic                       fetch_err;
    logic [1:0]                 is_sw;
    logic [7:0]                 is_hw;
    logic                       is_ipi;

    // Masked write terms shared by every field
    assign wr_set  = csr_wmask & csr_wvalue;
    assign wr_keep = ~csr_wmask;

    assign wr_crmd   = csr_we && (csr_num == csr_pkg::CSR_CRMD);
    assign wr_prmd   = csr_we && (csr_num == csr_pkg::CSR_PRMD);
    assign wr_ecfg   = csr_we && (csr_num == csr_pkg::CSR_ECFG);
    assign wr_estat  = csr_we && (csr_num == csr_pkg::CSR_ESTAT);
    assign wr_era    = csr_we && (csr_num == csr_pkg::CSR_ERA);
    assign wr_eentry = csr_we && (csr_num == csr_pkg::CSR_EENTRY);

    assign addr_err  = (wb_ecode == csr_pkg::ECODE_ADE) || (wb_ecode == csr_pkg::ECODE_ALE);
    assign fetch_err = (wb_ecode == csr_pkg::ECODE_ADE) && (wb_esubcode == csr_pkg::ESUB_ADEF);

    // --------------------
    // CRMD and PRMD
    // --------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= wr_set[1:0] | (wr_keep[1:0] & crmd_plv);
            crmd_ie  <= wr_set[2] | (wr_keep[2] & crmd_ie);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd) begin
            prmd_pplv <= wr_set[1:0] | (wr_keep[1:0] & prmd_pplv);
            prmd_pie  <= wr_set[2] | (wr_keep[2] & prmd_pie);
        end
    end

    // --------------------
    // ECFG and ESTAT
    // --------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie <= '0;
        end else if (wr_ecfg) begin
            ecfg_lie <= (wr_set[12:0] | (wr_keep[12:0] & ecfg_lie)) & csr_pkg::LIE_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            is_sw  <= '0;
            is_hw  <= '0;
            is_ipi <= 1'b0;
        end else begin
            if (wr_estat) begin
                is_sw <= wr_set[1:0] | (wr_keep[1:0] & is_sw);
            end
            // External lines sampled every cycle
            is_hw  <= hw_int_in;
            is_ipi <= ipi_int_in;
        end
    end

    // Bits 10 and 11 stay zero here, the timer bit is merged on read
    assign estat_is = {is_ipi, 2'b00, is_hw, is_sw};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    // --------------------
    // ERA, BADV, EENTRY
    // --------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            era_pc <= '0;
        end else if (wb_ex) begin
            era_pc <= wb_pc;
        end else if (wr_era) begin
            era_pc <= wr_set | (wr_keep & era_pc);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            badv_vaddr <= '0;
        end else if (wb_ex && addr_err) begin
            badv_vaddr <= fetch_err ? wb_pc : wb_vaddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= '0;
        end else if (wr_eentry) begin
            eentry_va <= wr_set[csr_pkg::DATA_W-1:VA_LSB]
                       | (wr_keep[csr_pkg::DATA_W-1:VA_LSB] & eentry_va);
        end
    end

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/1ns

module csr_file (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [csr_pkg::NUM_W-1:0]     csr_num,
    input  logic                          csr_we,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wvalue,
    input  logic                          wb_ex,
    input  logic [csr_pkg::DATA_W-1:0]    wb_pc,
    input  logic [csr_pkg::DATA_W-1:0]    wb_vaddr,
    input  logic [5:0]                    wb_ecode,
    input  logic [8:0]                    wb_esubcode,
    input  logic                          ertn_flush,
    input  logic [7:0]                    hw_int_in,
    input  logic                          ipi_int_in,
    output logic [csr_pkg::DATA_W-1:0]    csr_rvalue,
    output logic [csr_pkg::DATA_W-1:0]    ex_entry,
    output logic [csr_pkg::DATA_W-1:0]    ertn_entry,
    output logic                          has_int,
    output logic [csr_pkg::PLV_W-1:0]     plv,
    output logic [5:0]                    stat_ecode
);

    logic [csr_pkg::PLV_W-1:0]       crmd_plv;
    logic                            crmd_ie;
    logic [csr_pkg::PLV_W-1:0]       prmd_pplv;
    logic                            prmd_pie;
    logic [csr_pkg::IS_W-1:0]        ecfg_lie;
    logic [csr_pkg::IS_W-1:0]        estat_is;
    logic [5:0]                      estat_ecode;
    logic [8:0]                      estat_esubcode;
    logic [csr_pkg::DATA_W-1:0]      era_pc;
    logic [csr_pkg::DATA_W-1:0]      badv_vaddr;
    logic [csr_pkg::EENTRY_VA_W-1:0] eentry_va;
    logic                            tcfg_en;
    logic                            tcfg_periodic;
    logic [csr_pkg::INITVAL_W-1:0]   tcfg_initval;
    logic [csr_pkg::DATA_W-1:0]      timer_cnt;
    logic                            timer_int;

    csr_exc_regs exc_regs_i (
        .clk            (clk),
        .resetn         (resetn),
        .csr_num        (csr_num),
        .csr_we         (csr_we),
        .csr_wmask      (csr_wmask),
        .csr_wvalue     (csr_wvalue),
        .wb_ex          (wb_ex),
        .wb_pc          (wb_pc),
        .wb_vaddr       (wb_vaddr),
        .wb_ecode       (wb_ecode),
        .wb_esubcode    (wb_esubcode),
        .ertn_flush     (ertn_flush),
        .hw_int_in      (hw_int_in),
        .ipi_int_in     (ipi_int_in),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is       (estat_is),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_va      (eentry_va)
    );

    csr_timer timer_i (
        .clk           (clk),
        .resetn        (resetn),
        .csr_num       (csr_num),
        .csr_we        (csr_we),
        .csr_wmask     (csr_wmask),
        .csr_wvalue    (csr_wvalue),
        .tcfg_en       (tcfg_en),
        .tcfg_periodic (tcfg_periodic),
        .tcfg_initval  (tcfg_initval),
        .timer_cnt     (timer_cnt),
        .timer_int     (timer_int)
    );

    csr_rd_irq rd_irq_i (
        .csr_num        (csr_num),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .estat_is       (estat_is),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_va      (eentry_va),
        .tcfg_en        (tcfg_en),
        .tcfg_periodic  (tcfg_periodic),
        .tcfg_initval   (tcfg_initval),
        .timer_cnt      (timer_cnt),
        .timer_int      (timer_int),
        .csr_rvalue     (csr_rvalue),
        .has_int        (has_int)
    );

    // Handler entry is 64-byte aligned
    assign ex_entry   = {eentry_va, 6'b0};
    assign ertn_entry = era_pc;
    assign plv        = crmd_plv;
    assign stat_ecode = estat_ecode;

endmodule

// File: hdl/csr_pkg.sv
package csr_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int DATA_W       = 32;
    localparam int NUM_W        = 14;
    localparam int PLV_W        = 2;
    localparam int IS_W         = 13;
    localparam int EENTRY_VA_W  = 26;
    localparam int INITVAL_W    = 30;

    // Timer interrupt position in ESTAT.IS
    localparam int TIMER_IS_BIT = 11;

    // --------------------
    // Field constants
    // --------------------
    // Bit 10 of ECFG.LIE is reserved
    localparam logic [IS_W-1:0]   LIE_MASK   = 13'h1bff;
    // Instruction fetch address error
    localparam logic [8:0]        ESUB_ADEF  = 9'd0;
    // Value held by a stopped counter
    localparam logic [DATA_W-1:0] TIMER_IDLE = 32'hffff_ffff;

    typedef enum logic [NUM_W-1:0] {
        CSR_CRMD   = 14'h00,
        CSR_PRMD   = 14'h01,
        CSR_ECFG   = 14'h04,
        CSR_ESTAT  = 14'h05,
        CSR_ERA    = 14'h06,
        CSR_BADV   = 14'h07,
        CSR_EENTRY = 14'h0c,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csr_addr_e;

    // Only the address error codes get special handling
    typedef enum logic [5:0] {
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09
    } ecode_e;

endpackage

// File: hdl/csr_rd_irq.sv
`timescale 1ns/1ns

module csr_rd_irq (
    input  logic [csr_pkg::NUM_W-1:0]          csr_num,
    input  logic [csr_pkg::PLV_W-1:0]          crmd_plv,
    input  logic                               crmd_ie,
    input  logic [csr_pkg::PLV_W-1:0]          prmd_pplv,
    input  logic                               prmd_pie,
    input  logic [csr_pkg::IS_W-1:0]           ecfg_lie,
    input  logic [csr_pkg::IS_W-1:0]           estat_is,
    input  logic [5:0]                         estat_ecode,
    input  logic [8:0]                         estat_esubcode,
    input  logic [csr_pkg::DATA_W-1:0]         era_pc,
    input  logic [csr_pkg::DATA_W-1:0]         badv_vaddr,
    input  logic [csr_pkg::EENTRY_VA_W-1:0]    eentry_va,
    input  logic                               tcfg_en,
    input  logic                               tcfg_periodic,
    input  logic [csr_pkg::INITVAL_W-1:0]      tcfg_initval,
    input  logic [csr_pkg::DATA_W-1:0]         timer_cnt,
    input  logic                               timer_int,
    output logic [csr_pkg::DATA_W-1:0]         csr_rvalue,
    output logic                               has_int
);

    logic [csr_pkg::IS_W-1:0] is_merged;

    always_comb begin
        is_merged = estat_is;
        is_merged[csr_pkg::TIMER_IS_BIT] = timer_int;
    end

    // IPI at bit 12 does not take part in the request
    assign has_int = crmd_ie && (|(is_merged[11:0] & ecfg_lie[11:0]));

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        case (csr_num)
            csr_pkg::CSR_CRMD:   csr_rvalue = {28'b0, 1'b1, crmd_ie, crmd_plv};
            csr_pkg::CSR_PRMD:   csr_rvalue = {29'b0, prmd_pie, prmd_pplv};
            csr_pkg::CSR_ECFG:   csr_rvalue = {19'b0, ecfg_lie};
            csr_pkg::CSR_ESTAT:  csr_rvalue = {1'b0, estat_esubcode, estat_ecode, 3'b0, is_merged};
            csr_pkg::CSR_ERA:    csr_rvalue = era_pc;
            csr_pkg::CSR_BADV:   csr_rvalue = badv_vaddr;
            csr_pkg::CSR_EENTRY: csr_rvalue = {eentry_va, 6'b0};
            csr_pkg::CSR_TCFG:   csr_rvalue = {tcfg_initval, tcfg_periodic, tcfg_en};
            csr_pkg::CSR_TVAL:   csr_rvalue = timer_cnt;
            // Write-only clear
            csr_pkg::CSR_TICLR:  csr_rvalue = '0;
            default:             csr_rvalue = '0;
        endcase
    end

endmodule

// File: hdl/csr_timer.sv
`timescale 1ns/1ns

module csr_timer (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic [csr_pkg::NUM_W-1:0]          csr_num,
    input  logic                               csr_we,
    input  logic [csr_pkg::DATA_W-1:0]         csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]         csr_wvalue,
    output logic                               tcfg_en,
    output logic                               tcfg_periodic,
    output logic [csr_pkg::INITVAL_W-1:0]      tcfg_initval,
    output logic [csr_pkg::DATA_W-1:0]         timer_cnt,
    output logic                               timer_int
);

    logic                       wr_tcfg;
    logic                       ticlr_clr;
    logic [csr_pkg::DATA_W-1:0] tcfg_next;

    assign wr_tcfg   = csr_we && (csr_num == csr_pkg::CSR_TCFG);
    assign ticlr_clr = csr_we && (csr_num == csr_pkg::CSR_TICLR)
                       && csr_wmask[0] && csr_wvalue[0];

    // TCFG as it will be after the write
    assign tcfg_next = (csr_wmask & csr_wvalue)
                     | (~csr_wmask & {tcfg_initval, tcfg_periodic, tcfg_en});

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_tcfg) begin
            tcfg_en       <= tcfg_next[0];
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[csr_pkg::DATA_W-1:2];
        end
    end

    // --------------------
    // Down-counter
    // --------------------
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= csr_pkg::TIMER_IDLE;
        end else if (wr_tcfg && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[csr_pkg::DATA_W-1:2], 2'b00};
        end else if (tcfg_en && (timer_cnt != csr_pkg::TIMER_IDLE)) begin
            if ((timer_cnt == '0) && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                // One-shot wraps to the idle value and stops there
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // Set beats TICLR in the same cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (ticlr_clr) begin
            timer_int <= 1'b0;
        end
    end

endmodule

// File: tb.f
hdl/csr_pkg.sv
hdl/csr_exc_regs.sv
hdl/csr_timer.sv
hdl/csr_rd_irq.sv
hdl/csr_file.sv
verification/csr_file_props.sv
verification/tb_csr_file.sv

// File: verification/csr_file_props.sv
`timescale 1ns/1ns

module csr_file_props (
    input logic                      clk,
    input logic                      resetn,
    input logic                      wb_ex,
    input logic                      ertn_flush,
    input logic                      has_int,
    input logic [csr_pkg::PLV_W-1:0] plv,
    input logic [csr_pkg::PLV_W-1:0] prmd_pplv
);

    int fail_cnt = 0;

    // No request right after reset
    has_int_after_reset: assert property (@(posedge clk) !resetn |=> !has_int)
        else begin
            fail_cnt++;
            $error("has_int high in the cycle after reset");
        end

    plv_after_ex: assert property (@(posedge clk) disable iff (!resetn)
        wb_ex |=> plv == '0)
        else begin
            fail_cnt++;
            $error("PLV not zero after exception entry");
        end

    // Return takes the saved level
    plv_after_ertn: assert property (@(posedge clk) disable iff (!resetn)
        (ertn_flush && !wb_ex) |=> plv == $past(prmd_pplv))
        else begin
            fail_cnt++;
            $error("PLV does not match PRMD.PPLV after ertn");
        end

endmodule

bind csr_file csr_file_props props_i (
    .clk        (clk),
    .resetn     (resetn),
    .wb_ex      (wb_ex),
    .ertn_flush (ertn_flush),
    .has_int    (has_int),
    .plv        (plv),
    .prmd_pplv  (prmd_pplv)
);

// File: verification/tb_csr_file.sv
`timescale 1ns/1ns

module tb_csr_file;

    localparam int TIMEOUT = 200;

    logic        clk;
    logic        resetn;
    logic [13:0] csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic        wb_ex;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic        ertn_flush;
    logic [7:0]  hw_int_in;
    logic        ipi_int_in;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;
    logic [31:0] ertn_entry;
    logic        has_int;
    logic [1:0]  plv;
    logic [5:0]  stat_ecode;

    // Reference state
    logic [1:0]  m_plv;
    logic        m_ie;
    logic [1:0]  m_pplv;
    logic        m_pie;
    logic [12:0] m_lie;
    logic [1:0]  m_sw;
    logic [7:0]  m_hw;
    logic        m_ipi;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic        m_en;
    logic        m_per;
    logic [29:0] m_init;
    logic [31:0] m_cnt;
    logic        m_tint;
    logic [31:0] rng;

    csr_file csr_file_i (
        .clk         (clk),
        .resetn      (resetn),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .csr_rvalue  (csr_rvalue),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .has_int     (has_int),
        .plv         (plv),
        .stat_ecode  (stat_ecode)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] merge_bits(input logic [31:0] old,
                                               input logic [31:0] mask,
                                               input logic [31:0] val);
        return (mask & val) | (~mask & old);
    endfunction

    function automatic logic [13:0] rw_addr(input logic [2:0] sel);
        case (sel)
            3'd0:    return csr_pkg::CSR_CRMD;
            3'd1:    return csr_pkg::CSR_PRMD;
            3'd2:    return csr_pkg::CSR_ECFG;
            3'd3:    return csr_pkg::CSR_ESTAT;
            3'd4:    return csr_pkg::CSR_ERA;
            default: return csr_pkg::CSR_EENTRY;
        endcase
    endfunction

    function automatic logic [31:0] ref_read(input logic [13:0] num);
        logic [12:0] is_all;
        is_all = {m_ipi, m_tint, 1'b0, m_hw, m_sw};
        case (num)
            csr_pkg::CSR_CRMD:   return {28'b0, 1'b1, m_ie, m_plv};
            csr_pkg::CSR_PRMD:   return {29'b0, m_pie, m_pplv};
            csr_pkg::CSR_ECFG:   return {19'b0, m_lie};
            csr_pkg::CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, is_all};
            csr_pkg::CSR_ERA:    return m_era;
            csr_pkg::CSR_BADV:   return m_badv;
            csr_pkg::CSR_EENTRY: return m_eentry;
            csr_pkg::CSR_TCFG:   return {m_init, m_per, m_en};
            csr_pkg::CSR_TVAL:   return m_cnt;
            default:             return 32'h0;
        endcase
    endfunction

    function automatic logic ref_has_int();
        return m_ie && (|({m_tint, 1'b0, m_hw, m_sw} & m_lie[11:0]));
    endfunction

    // --------------------
    // Reference model
    // --------------------
    always @(posedge clk) begin
        logic [31:0] nw;
        logic [31:0] tn;
        logic        tcfg_wr;
        if (!resetn) begin
            m_plv    <= '0;
            m_ie     <= 1'b0;
            m_pplv   <= '0;
            m_pie    <= 1'b0;
            m_lie    <= '0;
            m_sw     <= '0;
            m_hw     <= '0;
            m_ipi    <= 1'b0;
            m_ecode  <= '0;
            m_esub   <= '0;
            m_era    <= '0;
            m_badv   <= '0;
            m_eentry <= '0;
            m_en     <= 1'b0;
            m_per    <= 1'b0;
            m_init   <= '0;
            m_cnt    <= csr_pkg::TIMER_IDLE;
            m_tint   <= 1'b0;
        end else begin
            if (wb_ex) begin
                m_plv   <= '0;
                m_ie    <= 1'b0;
                m_pplv  <= m_plv;
                m_pie   <= m_ie;
                m_era   <= wb_pc;
                m_ecode <= wb_ecode;
                m_esub  <= wb_esubcode;
                if (wb_ecode == csr_pkg::ECODE_ADE && wb_esubcode == csr_pkg::ESUB_ADEF) begin
                    m_badv <= wb_pc;
                end else if (wb_ecode == csr_pkg::ECODE_ADE || wb_ecode == csr_pkg::ECODE_ALE) begin
                    m_badv <= wb_vaddr;
                end
            end else if (ertn_flush) begin
                m_plv <= m_pplv;
                m_ie  <= m_pie;
            end
            if (csr_we) begin
                case (csr_num)
                    csr_pkg::CSR_CRMD: begin
                        nw = merge_bits({29'b0, m_ie, m_plv}, csr_wmask, csr_wvalue);
                        if (!wb_ex && !ertn_flush) begin
                            m_plv <= nw[1:0];
                            m_ie  <= nw[2];
                        end
                    end
                    csr_pkg::CSR_PRMD: begin
                        nw = merge_bits({29'b0, m_pie, m_pplv}, csr_wmask, csr_wvalue);
                        if (!wb_ex) begin
                            m_pplv <= nw[1:0];
                            m_pie  <= nw[2];
                        end
                    end
                    csr_pkg::CSR_ECFG: begin
                        nw = merge_bits({19'b0, m_lie}, csr_wmask, csr_wvalue);
                        m_lie <= nw[12:0] & csr_pkg::LIE_MASK;
                    end
                    csr_pkg::CSR_ESTAT: begin
                        nw = merge_bits({30'b0, m_sw}, csr_wmask, csr_wvalue);
                        m_sw <= nw[1:0];
                    end
                    csr_pkg::CSR_ERA: begin
                        if (!wb_ex) begin
                            m_era <= merge_bits(m_era, csr_wmask, csr_wvalue);
                        end
                    end
                    csr_pkg::CSR_EENTRY: begin
                        nw = merge_bits(m_eentry, csr_wmask, csr_wvalue);
                        m_eentry <= {nw[31:6], 6'b0};
                    end
                    default: ;
                endcase
            end
            m_hw  <= hw_int_in;
            m_ipi <= ipi_int_in;

            // Timer
            tn = merge_bits({m_init, m_per, m_en}, csr_wmask, csr_wvalue);
            tcfg_wr = csr_we && (csr_num == csr_pkg::CSR_TCFG);
            if (tcfg_wr) begin
                m_en   <= tn[0];
                m_per  <= tn[1];
                m_init <= tn[31:2];
            end
            if (tcfg_wr && tn[0]) begin
                m_cnt <= {tn[31:2], 2'b00};
            end else if (m_en && m_cnt != csr_pkg::TIMER_IDLE) begin
                m_cnt <= (m_cnt == 32'h0 && m_per) ? {m_init, 2'b00} : m_cnt - 32'd1;
            end
            if (m_cnt == 32'h0) begin
                m_tint <= 1'b1;
            end else if (csr_we && csr_num == csr_pkg::CSR_TICLR
                         && csr_wmask[0] && csr_wvalue[0]) begin
                m_tint <= 1'b0;
            end
        end
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Outputs compared with the model in the middle of every cycle
    always @(negedge clk) begin
        if (resetn) begin
            check_equal("csr_rvalue", csr_rvalue, ref_read(csr_num));
            check_equal("has_int", 32'(has_int), 32'(ref_has_int()));
            check_equal("plv", 32'(plv), 32'(m_plv));
            check_equal("ex_entry", ex_entry, m_eentry);
            check_equal("ertn_entry", ertn_entry, m_era);
            check_equal("stat_ecode", 32'(stat_ecode), 32'(m_ecode));
        end
    end

    // --------------------
    // Stimulus tasks
    // --------------------
    // Each task starts and ends right after a rising edge
    task automatic csr_write(input logic [13:0] num, input logic [31:0] mask,
                             input logic [31:0] val);
        csr_num    <= num;
        csr_we     <= 1'b1;
        csr_wmask  <= mask;
        csr_wvalue <= val;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic read_csr(input logic [13:0] num, output logic [31:0] data);
        csr_num <= num;
        @(negedge clk);
        data = csr_rvalue;
        @(posedge clk);
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] esub,
                                   input logic [31:0] pc, input logic [31:0] vaddr,
                                   input logic with_ertn);
        wb_ex       <= 1'b1;
        wb_ecode    <= ecode;
        wb_esubcode <= esub;
        wb_pc       <= pc;
        wb_vaddr    <= vaddr;
        ertn_flush  <= with_ertn;
        @(posedge clk);
        wb_ex      <= 1'b0;
        ertn_flush <= 1'b0;
    endtask

    task automatic ertn_return();
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    task automatic wait_timer_flag();
        logic [31:0] d;
        int i;
        for (i = 0; i < TIMEOUT; i++) begin
            read_csr(csr_pkg::CSR_ESTAT, d);
            if (d[csr_pkg::TIMER_IS_BIT]) break;
        end
        if (i == TIMEOUT) begin
            $display("Timeout: the timer interrupt bit in ESTAT never set");
            $display("SOME TESTS FAILED");
            $fatal(1, "timer wait timed out");
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] d;
        logic [31:0] mask;
        logic [31:0] val;
        logic [31:0] pc;
        logic [31:0] va;
        int i;
        resetn      = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        rng         = 32'h2b3e8316;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        // Masked writes and readback
        for (i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            mask = rng;
            rng = xorshift32(rng);
            val = rng;
            csr_write(rw_addr(mask[31:29]), mask, val);
            read_csr(rw_addr(mask[31:29]), d);
        end
        csr_write(csr_pkg::CSR_ECFG, 32'hffff_ffff, 32'hffff_ffff);
        read_csr(csr_pkg::CSR_ECFG, d);
        check_equal("ecfg", d, 32'h0000_1bff);
        read_csr(csr_pkg::CSR_CRMD, d);
        check_equal("crmd_da", 32'(d[3]), 32'd1);
        read_csr(14'h3ff, d);
        check_equal("unknown_csr", d, 32'h0);

        // Exception entry
        csr_write(csr_pkg::CSR_CRMD, 32'h7, 32'h7);
        csr_write(csr_pkg::CSR_EENTRY, 32'hffff_ffff, 32'h1c00_8040);
        rng = xorshift32(rng);
        pc = rng;
        rng = xorshift32(rng);
        va = rng;
        raise_exception(csr_pkg::ECODE_ADE, csr_pkg::ESUB_ADEF, pc, va, 1'b0);
        read_csr(csr_pkg::CSR_BADV, d);
        check_equal("badv_adef", d, pc);
        read_csr(csr_pkg::CSR_CRMD, d);
        check_equal("crmd_after_ex", d, 32'h8);
        read_csr(csr_pkg::CSR_PRMD, d);
        check_equal("prmd_after_ex", d, 32'h7);
        read_csr(csr_pkg::CSR_ERA, d);
        check_equal("era", d, pc);
        raise_exception(csr_pkg::ECODE_ALE, 9'h005, va, pc, 1'b0);
        read_csr(csr_pkg::CSR_BADV, d);
        check_equal("badv_ale", d, pc);

        // Exception return, then both events in one cycle
        csr_write(csr_pkg::CSR_PRMD, 32'h7, 32'h6);
        ertn_return();
        read_csr(csr_pkg::CSR_CRMD, d);
        check_equal("crmd_after_ertn", d, 32'he);
        raise_exception(6'h01, 9'h0, pc, va, 1'b1);
        read_csr(csr_pkg::CSR_CRMD, d);
        check_equal("crmd_ex_over_ertn", d, 32'h8);
        read_csr(csr_pkg::CSR_PRMD, d);
        check_equal("prmd_ex_over_ertn", d, 32'h6);

        // One-shot timer, initval 5
        csr_write(csr_pkg::CSR_TCFG, 32'hffff_ffff, 32'h15);
        for (i = 0; i < 4; i++) begin
            read_csr(csr_pkg::CSR_TVAL, d);
            check_equal("tval", d, 32'd20 - i);
        end
        wait_timer_flag();
        read_csr(csr_pkg::CSR_TVAL, d);
        check_equal("tval_idle", d, csr_pkg::TIMER_IDLE);
        csr_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        read_csr(csr_pkg::CSR_ESTAT, d);
        check_equal("estat_ti", 32'(d[csr_pkg::TIMER_IS_BIT]), 32'd0);

        // Periodic timer, initval 3
        csr_write(csr_pkg::CSR_TCFG, 32'hffff_ffff, 32'h0f);
        wait_timer_flag();
        csr_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        wait_timer_flag();

        // Interrupt request combinations
        for (i = 0; i < 24; i++) begin
            rng = xorshift32(rng);
            hw_int_in  <= rng[7:0];
            ipi_int_in <= rng[8];
            csr_write(csr_pkg::CSR_ECFG, 32'h1fff, {19'b0, rng[21:9]});
            csr_write(csr_pkg::CSR_CRMD, 32'h4, {29'b0, rng[22], 2'b0});
            if (rng[23]) begin
                csr_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
            end
            @(negedge clk);
            check_equal("has_int", 32'(has_int), 32'(ref_has_int()));
            @(posedge clk);
        end
        csr_write(csr_pkg::CSR_TCFG, 32'h1, 32'h0);
        repeat (2) @(posedge clk);

        if (csr_file_i.props_i.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("Property checks on csr_file reported failures");
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
